// File: project.f
logic/tx_pkg.sv
logic/frame_q_if.sv
logic/descriptor_accumulator.sv
logic/frame_queue.sv
logic/eth_crc32.sv
logic/gmii_tx_engine.sv
logic/gmii_tx.sv
tests/gmii_tx_assert.sv
tests/tb_gmii_tx.sv

// File: Bender.yml
package:
  name: gmii_tx

sources:
  - logic/tx_pkg.sv
  - logic/frame_q_if.sv
  - logic/descriptor_accumulator.sv
  - logic/frame_queue.sv
  - logic/eth_crc32.sv
  - logic/gmii_tx_engine.sv
  - logic/gmii_tx.sv
  - target: test
    files:
      - tests/gmii_tx_assert.sv
      - tests/tb_gmii_tx.sv

// File: tests/tb_gmii_tx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gmii_tx;

    logic tx_clk, rst_n, ether_en, tx_stop, tfc_pause, pause_send, pause_send_zero, crcfwd;
    logic [31:0] palr, paur, opd;
    tx_pkg::ipg_t  tipg;
    tx_pkg::word_t data_rdata;
    tx_pkg::desc_t desc_rdata;
    logic [5:0]    desc_cnt;
    tx_pkg::byte_t gmii_txd;
    logic gmii_tx_en, tx_mac_stop, pause_mac_send, pause_mac_send_zero, data_pop, desc_pop;

    tx_pkg::desc_t      desc_fifo[$];
    tx_pkg::word_t      data_mem[0:1023];
    int                 data_rd, data_wr;
    tx_pkg::byte_t      exp_bytes[$];
    tx_pkg::frame_len_t exp_lens[$];
    int                 exp_kinds[$];
    tx_pkg::byte_t      pend_body[$];
    logic               pend_fcs;
    int unsigned        seed;
    longint             cycles, limit;
    logic               in_frame, had_frame, cut;
    int                 nbytes, pulses, zpulses, gap, kind, left;

    gmii_tx dut_i (.*);

    initial begin
        tx_clk = 1'b0;
        forever #2 tx_clk = ~tx_clk;
    end

    task automatic stop_run(input string why);
        if (why != "") $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input tx_pkg::byte_t exp,
                              input tx_pkg::byte_t act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_run("");
        end
    endtask

    task automatic check_len(input string name, input tx_pkg::frame_len_t exp,
                             input tx_pkg::frame_len_t act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run("");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
            stop_run("");
        end
    endtask

    // preamble, sfd, body, then fcs lsb first
    function automatic void expected_frame(input tx_pkg::byte_t body[$], input logic fcs_on,
                                           input int frame_kind);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < 7; i++) exp_bytes.push_back(8'h55);
        exp_bytes.push_back(8'hD5);
        foreach (body[i]) begin
            exp_bytes.push_back(body[i]);
            c = c ^ {24'h0, body[i]};
            for (int k = 0; k < 8; k++) c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        c = ~c;
        if (fcs_on) begin
            for (int i = 0; i < 4; i++) exp_bytes.push_back(c[8*i +: 8]);
        end
        exp_lens.push_back(16'(8 + body.size() + (fcs_on ? 4 : 0)));
        exp_kinds.push_back(frame_kind);
        limit = limit + 2 * (body.size() + 12 + tipg + 2);
    endfunction

    task automatic send_frame(input int len, input int ndesc, input logic nofcs);
        int remaining, part;
        pend_body.delete();
        remaining = len;
        if (ndesc > len) ndesc = len;
        for (int i = 0; i < len; i++) begin
            pend_body.push_back(8'($urandom));
            data_mem[(data_wr + i / 8) % 1024][8 * (i % 8) +: 8] = pend_body[i];
        end
        data_wr = data_wr + (len + 7) / 8;
        for (int d = 0; d < ndesc; d++) begin
            part = (d == ndesc - 1) ? remaining : remaining / (ndesc - d);
            remaining = remaining - part;
            desc_fifo.push_back({2'b00, d == ndesc - 1, nofcs, 16'(part)});
        end
        pend_fcs = !nofcs && !crcfwd;
    endtask

    task automatic request_pause(input logic zero);
        tx_pkg::byte_t body[$];
        for (int i = 5; i >= 0; i--) body.push_back(tx_pkg::PAUSE_DEST[8*i +: 8]);
        for (int i = 3; i >= 0; i--) body.push_back(palr[8*i +: 8]);
        for (int i = 3; i >= 0; i--) body.push_back(paur[8*i +: 8]);
        for (int i = 3; i >= 0; i--) body.push_back((zero && i < 2) ? 8'h00 : opd[8*i +: 8]);
        for (int i = 0; i < 34; i++) body.push_back(8'h00);
        expected_frame(body, 1'b1, zero ? 2 : 1);
        if (zero) pause_send_zero <= 1'b1;
        else pause_send <= 1'b1;
        @(posedge tx_clk);
        pause_send      <= 1'b0;
        pause_send_zero <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge tx_clk); while (exp_bytes.size() != 0 || !tx_mac_stop);
    endtask

    // descriptor fifo and fwft data fifo models
    always @(posedge tx_clk) begin
        if (desc_pop) desc_fifo.delete(0);
        desc_cnt   <= (desc_fifo.size() > 63) ? 6'd63 : 6'(desc_fifo.size());
        desc_rdata <= (desc_fifo.size() != 0) ? desc_fifo[0] : '0;
        if (!ether_en) data_rd = data_wr;
        else if (data_pop) data_rd = data_rd + 1;
        data_rdata <= data_mem[data_rd % 1024];
    end

    always @(posedge tx_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) stop_run("timeout: the run did not finish within its cycle budget");
    end

    always @(posedge tx_clk) begin
        if (gmii_tx_en) begin
            if (!in_frame) begin
                in_frame = 1'b1;
                cut = 1'b0;
                nbytes = 0;
                pulses = 0;
                zpulses = 0;
                if (had_frame) check_flag("inter-frame gap long enough", 1'b1, gap > tipg);
            end
            // flush seen while the frame is on the wire
            if (!ether_en) cut = 1'b1;
            if (exp_bytes.size() == 0) stop_run("a frame byte was sent while none was expected");
            check_byte("gmii_txd", exp_bytes.pop_front(), gmii_txd);
            check_flag("tx_mac_stop", 1'b0, tx_mac_stop);
            nbytes = nbytes + 1;
            pulses = pulses + pause_mac_send;
            zpulses = zpulses + pause_mac_send_zero;
        end else begin
            if (in_frame) begin
                in_frame = 1'b0;
                had_frame = 1'b1;
                gap = 0;
                kind = exp_kinds.pop_front();
                if (cut) begin
                    // rest of the aborted frame never goes out
                    left = int'(exp_lens.pop_front()) - nbytes;
                    for (int i = 0; i < left; i++) exp_bytes.delete(0);
                end else begin
                    check_len("frame length", exp_lens.pop_front(), 16'(nbytes));
                    check_len("pause_mac_send pulses", 16'(kind == 1), 16'(pulses));
                    check_len("pause_mac_send_zero pulses", 16'(kind == 2), 16'(zpulses));
                end
            end
            gap = gap + 1;
        end
    end

    initial begin
        seed = $urandom(32'h349b03fc);
        rst_n = 1'b0;
        ether_en = 1'b1;
        {tx_stop, tfc_pause, pause_send, pause_send_zero, crcfwd} = '0;
        palr = $urandom;
        paur = $urandom;
        opd  = $urandom;
        tipg = 16'd12;
        desc_cnt = '0;
        desc_rdata = '0;
        data_rdata = '0;
        for (int i = 0; i < 1024; i++) data_mem[i] = {32'(i), ~32'(i)};
        {data_rd, data_wr, gap, nbytes, pulses, zpulses, left} = '0;
        {in_frame, had_frame, cut} = '0;
        cycles = 0;
        limit = 600;
        repeat (8) @(posedge tx_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge tx_clk);

        for (int i = 0; i < 8; i++) begin
            send_frame(1 + $urandom % 200, 1 + $urandom % 3, 1'b0);
            expected_frame(pend_body, pend_fcs, 0);
        end
        wait_idle();
        for (int i = 0; i < 3; i++) begin
            send_frame(1 + $urandom % 200, 1 + $urandom % 2, 1'b1);
            expected_frame(pend_body, pend_fcs, 0);
        end
        wait_idle();
        crcfwd <= 1'b1;
        @(posedge tx_clk);
        send_frame(1 + $urandom % 200, 2, 1'b0);
        expected_frame(pend_body, pend_fcs, 0);
        wait_idle();
        crcfwd <= 1'b0;

        request_pause(1'b0);
        wait_idle();
        request_pause(1'b1);
        wait_idle();

        // held data frame, pause still goes out first
        tx_stop <= 1'b1;
        @(posedge tx_clk);
        send_frame(1 + $urandom % 200, 1, 1'b0);
        repeat (30) @(posedge tx_clk);
        request_pause(1'b0);
        wait_idle();
        expected_frame(pend_body, pend_fcs, 0);
        tx_stop <= 1'b0;
        wait_idle();

        // flush in the middle of a pause frame, held data frames dropped
        tx_stop <= 1'b1;
        send_frame(1 + $urandom % 200, 2, 1'b0);
        send_frame(1 + $urandom % 200, 1, 1'b0);
        repeat (20) @(posedge tx_clk);
        request_pause(1'b0);
        repeat (20) @(posedge tx_clk);
        ether_en <= 1'b0;
        repeat (4) @(posedge tx_clk);
        check_flag("gmii_tx_en", 1'b0, gmii_tx_en);
        check_flag("tx_mac_stop", 1'b1, tx_mac_stop);
        ether_en <= 1'b1;
        tx_stop  <= 1'b0;
        repeat (60) @(posedge tx_clk);
        send_frame(1 + $urandom % 200, 3, 1'b0);
        expected_frame(pend_body, pend_fcs, 0);
        wait_idle();

        if (exp_bytes.size() == 0 && !in_frame) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/gmii_tx_assert.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_tx_assert (
    input logic tx_clk,
    input logic rst_n,
    input logic gmii_tx_en,
    input logic tx_mac_stop,
    input logic data_pop,
    input logic pause_mac_send,
    input logic pause_mac_send_zero
);

    idle_excl: assert property (@(posedge tx_clk) disable iff (!rst_n)
        !(gmii_tx_en && tx_mac_stop))
        else $error("gmii_tx_en and tx_mac_stop high together");

    pop_single: assert property (@(posedge tx_clk) disable iff (!rst_n)
        data_pop |=> !data_pop)
        else $error("data_pop high in two consecutive cycles");

    // pause pulses are one cycle wide, inside the frame
    pause_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        pause_mac_send |-> gmii_tx_en ##1 !pause_mac_send)
        else $error("pause_mac_send pulse malformed");

    zero_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        pause_mac_send_zero |-> gmii_tx_en ##1 !pause_mac_send_zero)
        else $error("pause_mac_send_zero pulse malformed");

endmodule

bind gmii_tx gmii_tx_assert assert_i (
    .tx_clk              (tx_clk),
    .rst_n               (rst_n),
    .gmii_tx_en          (gmii_tx_en),
    .tx_mac_stop         (tx_mac_stop),
    .data_pop            (data_pop),
    .pause_mac_send      (pause_mac_send),
    .pause_mac_send_zero (pause_mac_send_zero)
);

`default_nettype wire

// File: logic/gmii_tx.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_tx (
    input  logic          tx_clk,
    input  logic          rst_n,
    input  logic          ether_en,

    output tx_pkg::byte_t gmii_txd,
    output logic          gmii_tx_en,

    input  logic          tx_stop,
    output logic          tx_mac_stop,
    input  logic          tfc_pause,
    input  logic          pause_send,
    output logic          pause_mac_send,
    input  logic          pause_send_zero,
    output logic          pause_mac_send_zero,
    input  logic          crcfwd,
    input  logic [31:0]   palr,
    input  logic [31:0]   paur,
    input  logic [31:0]   opd,
    input  tx_pkg::ipg_t  tipg,

    // first-word-fall-through payload fifo
    output logic          data_pop,
    input  tx_pkg::word_t data_rdata,

    // descriptor fifo
    output logic          desc_pop,
    input  logic [5:0]    desc_cnt,
    input  tx_pkg::desc_t desc_rdata
);

    frame_q_if frame_q ();

    descriptor_accumulator accum_i (
        .tx_clk     (tx_clk),
        .rst_n      (rst_n),
        .ether_en   (ether_en),
        .desc_cnt   (desc_cnt),
        .desc_rdata (desc_rdata),
        .desc_pop   (desc_pop),
        .q          (frame_q.producer)
    );

    frame_queue queue_i (
        .tx_clk   (tx_clk),
        .rst_n    (rst_n),
        .ether_en (ether_en),
        .q        (frame_q.buffer)
    );

    gmii_tx_engine engine_i (
        .tx_clk              (tx_clk),
        .rst_n               (rst_n),
        .ether_en            (ether_en),
        .tx_stop             (tx_stop),
        .pause_send          (pause_send),
        .tfc_pause           (tfc_pause),
        .pause_send_zero     (pause_send_zero),
        .crcfwd              (crcfwd),
        .palr                (palr),
        .paur                (paur),
        .opd                 (opd),
        .tipg                (tipg),
        .data_rdata          (data_rdata),
        .data_pop            (data_pop),
        .gmii_txd            (gmii_txd),
        .gmii_tx_en          (gmii_tx_en),
        .tx_mac_stop         (tx_mac_stop),
        .pause_mac_send      (pause_mac_send),
        .pause_mac_send_zero (pause_mac_send_zero),
        .q                   (frame_q.consumer)
    );

endmodule

`default_nettype wire

// File: logic/gmii_tx_engine.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_tx_engine (
    input  logic          tx_clk,
    input  logic          rst_n,
    input  logic          ether_en,
    input  logic          tx_stop,
    input  logic          pause_send,
    input  logic          tfc_pause,
    input  logic          pause_send_zero,
    input  logic          crcfwd,
    input  logic [31:0]   palr,
    input  logic [31:0]   paur,
    input  logic [31:0]   opd,
    input  tx_pkg::ipg_t  tipg,
    input  tx_pkg::word_t data_rdata,
    output logic          data_pop,
    output tx_pkg::byte_t gmii_txd,
    output logic          gmii_tx_en,
    output logic          tx_mac_stop,
    output logic          pause_mac_send,
    output logic          pause_mac_send_zero,
    frame_q_if.consumer   q
);

    tx_pkg::tx_state_t  state;
    tx_pkg::frame_len_t pos;
    logic [$clog2(tx_pkg::BYTES_PER_WORD)-1:0] byte_idx;

    logic          crc_en;
    logic          crc_flush;
    tx_pkg::crc_t  crc_next;
    tx_pkg::crc_t  crc_val;
    tx_pkg::crc_t  fcs_shift;

    tx_pkg::byte_t preamble_byte;
    tx_pkg::byte_t data_byte;
    tx_pkg::byte_t pause_byte;
    logic [143:0]  pause_field;
    logic [143:0]  pause_shift;
    logic [4:0]    field_off;
    logic          no_fcs;

    eth_crc32 crc_i (
        .tx_clk   (tx_clk),
        .rst_n    (rst_n),
        .flush    (crc_flush),
        .data_en  (crc_en),
        .data_in  (gmii_txd),
        .crc_next (crc_next),
        .crc      (crc_val)
    );

    // crc preset held while idle, bytes fed back from the wire register
    assign crc_flush = (state == tx_pkg::TX_IDLE);

    assign preamble_byte = (pos == tx_pkg::PREAMBLE_LEN - 1'b1) ? tx_pkg::SFD_BYTE
                                                                 : tx_pkg::PREAMBLE_BYTE;

    assign data_byte = data_rdata[{byte_idx, 3'b000} +: 8];

    // zero variant clears the low half of opd
    assign pause_field = {tx_pkg::PAUSE_DEST, palr, paur,
                          (state == tx_pkg::TX_SEND_ZERO) ? {opd[31:16], 16'h0000} : opd};
    assign field_off   = 5'(pos - tx_pkg::PREAMBLE_LEN);
    assign pause_shift = pause_field << {field_off, 3'b000};
    assign pause_byte  = (pos < tx_pkg::PAUSE_FIELD_END) ? pause_shift[143:136] : 8'h00;

    assign fcs_shift = crc_val << {pos[1:0], 3'b000};

    assign no_fcs = crcfwd || q.head_no_fcs;

    assign q.pop = (state == tx_pkg::TX_SEND_DATA) && (pos == q.head_len);

    assign tx_mac_stop = (state == tx_pkg::TX_IDLE);
    assign pause_mac_send = (state == tx_pkg::TX_SEND_PAUSE) &&
                            (pos == tx_pkg::PAUSE_LAST_POS);
    assign pause_mac_send_zero = (state == tx_pkg::TX_SEND_ZERO) &&
                                 (pos == tx_pkg::PAUSE_LAST_POS);

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= tx_pkg::TX_IDLE;
            pos        <= '0;
            byte_idx   <= '0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            data_pop   <= 1'b0;
            crc_en     <= 1'b0;
        end else if (!ether_en) begin
            state      <= tx_pkg::TX_IDLE;
            pos        <= '0;
            byte_idx   <= '0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            data_pop   <= 1'b0;
            crc_en     <= 1'b0;
        end else begin
            data_pop <= 1'b0;
            case (state)
                tx_pkg::TX_IDLE: begin
                    gmii_tx_en <= 1'b0;
                    crc_en     <= 1'b0;
                    pos        <= '0;
                    byte_idx   <= '0;
                    if (pause_send || tfc_pause) begin
                        state <= tx_pkg::TX_SEND_PAUSE;
                    end else if (pause_send_zero) begin
                        state <= tx_pkg::TX_SEND_ZERO;
                    end else if (q.not_empty && !tx_stop) begin
                        state <= tx_pkg::TX_SEND_DATA;
                    end
                end
                tx_pkg::TX_SEND_PAUSE, tx_pkg::TX_SEND_ZERO: begin
                    gmii_tx_en <= 1'b1;
                    if (pos < tx_pkg::PREAMBLE_LEN) begin
                        gmii_txd <= preamble_byte;
                        crc_en   <= 1'b0;
                        pos      <= pos + 1'b1;
                    end else begin
                        gmii_txd <= pause_byte;
                        crc_en   <= 1'b1;
                        if (pos == tx_pkg::PAUSE_LAST_POS) begin
                            pos   <= '0;
                            state <= tx_pkg::TX_SEND_FCS;
                        end else begin
                            pos <= pos + 1'b1;
                        end
                    end
                end
                tx_pkg::TX_SEND_DATA: begin
                    gmii_tx_en <= 1'b1;
                    if (pos < tx_pkg::PREAMBLE_LEN) begin
                        gmii_txd <= preamble_byte;
                        crc_en   <= 1'b0;
                        pos      <= pos + 1'b1;
                    end else if (pos == q.head_len) begin
                        // release a partly used last word
                        data_pop <= (byte_idx != '0) &&
                                    (byte_idx != tx_pkg::BYTES_PER_WORD - 1);
                        byte_idx <= '0;
                        crc_en   <= 1'b0;
                        pos      <= 16'd1;
                        if (no_fcs) begin
                            gmii_txd   <= '0;
                            gmii_tx_en <= 1'b0;
                            state      <= tx_pkg::TX_WAIT_IPG;
                        end else begin
                            // first fcs byte leaves right away
                            gmii_txd <= crc_next[31:24];
                            state    <= tx_pkg::TX_SEND_FCS;
                        end
                    end else begin
                        gmii_txd <= data_byte;
                        crc_en   <= 1'b1;
                        data_pop <= (byte_idx == tx_pkg::BYTES_PER_WORD - 2);
                        byte_idx <= byte_idx + 1'b1;
                        pos      <= pos + 1'b1;
                    end
                end
                tx_pkg::TX_SEND_FCS: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b0;
                    if (pos == '0) begin
                        gmii_txd <= crc_next[31:24];
                    end else begin
                        gmii_txd <= fcs_shift[31:24];
                    end
                    if (pos == tx_pkg::FCS_LEN - 1'b1) begin
                        pos   <= 16'd1;
                        state <= tx_pkg::TX_WAIT_IPG;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end
                tx_pkg::TX_WAIT_IPG: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= '0;
                    crc_en     <= 1'b0;
                    if (pos >= tipg) begin
                        pos   <= '0;
                        state <= tx_pkg::TX_IDLE;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end
                default: begin
                    state <= tx_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/eth_crc32.sv
`timescale 1ns/100ps
`default_nettype none

module eth_crc32 (
    input  logic         tx_clk,
    input  logic         rst_n,
    input  logic         flush,
    input  logic         data_en,
    input  tx_pkg::byte_t data_in,
    output tx_pkg::crc_t crc_next,
    output tx_pkg::crc_t crc
);

    tx_pkg::crc_t crc_r;
    tx_pkg::crc_t crc_upd;
    tx_pkg::crc_t crc_sel;

    // lsb first, one byte per call
    function automatic tx_pkg::crc_t crc_byte(tx_pkg::crc_t c, tx_pkg::byte_t d);
        tx_pkg::crc_t r;
        r = c ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ tx_pkg::CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    // complement, first wire byte in bits 31:24
    function automatic tx_pkg::crc_t fcs_order(tx_pkg::crc_t c);
        tx_pkg::crc_t n;
        n = ~c;
        return {n[7:0], n[15:8], n[23:16], n[31:24]};
    endfunction

    assign crc_upd = crc_byte(crc_r, data_in);
    assign crc_sel = data_en ? crc_upd : crc_r;

    assign crc_next = fcs_order(crc_sel);
    assign crc      = fcs_order(crc_r);

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_r <= '1;
        end else if (flush) begin
            crc_r <= '1;
        end else if (data_en) begin
            crc_r <= crc_upd;
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_queue.sv
`timescale 1ns/100ps
`default_nettype none

module frame_queue (
    input  logic      tx_clk,
    input  logic      rst_n,
    input  logic      ether_en,
    frame_q_if.buffer q
);

    localparam int PTR_W = $clog2(tx_pkg::FRAME_Q_DEPTH);

    tx_pkg::frame_len_t len_mem [tx_pkg::FRAME_Q_DEPTH];
    logic               no_fcs_mem [tx_pkg::FRAME_Q_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && q.not_empty;

    assign q.full      = (count == tx_pkg::FRAME_Q_DEPTH);
    assign q.not_empty = (count != '0);
    assign q.head_len    = len_mem[rd_ptr];
    assign q.head_no_fcs = no_fcs_mem[rd_ptr];

    always_ff @(posedge tx_clk) begin
        if (do_push) begin
            len_mem[wr_ptr]    <= q.push_len;
            no_fcs_mem[wr_ptr] <= q.push_no_fcs;
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!ether_en) begin
            // flush drops every queued frame
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/descriptor_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module descriptor_accumulator (
    input  logic          tx_clk,
    input  logic          rst_n,
    input  logic          ether_en,
    input  logic [5:0]    desc_cnt,
    input  tx_pkg::desc_t desc_rdata,
    output logic          desc_pop,
    frame_q_if.producer   q
);

    tx_pkg::frame_len_t len_sum;
    tx_pkg::frame_len_t desc_len;
    logic               desc_last;

    assign desc_len  = desc_rdata[tx_pkg::DESC_LEN_MSB:0];
    assign desc_last = desc_rdata[tx_pkg::DESC_LAST_BIT];

    // a full queue stalls the descriptor fifo
    assign desc_pop = ether_en && (desc_cnt != 6'd0) && !q.full;

    // entry goes out in the same cycle as the last descriptor
    assign q.push        = desc_pop && desc_last;
    assign q.push_len    = len_sum + desc_len;
    assign q.push_no_fcs = desc_rdata[tx_pkg::DESC_NO_FCS_BIT];

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            len_sum <= tx_pkg::PREAMBLE_LEN;
        end else if (!ether_en) begin
            len_sum <= tx_pkg::PREAMBLE_LEN;
        end else if (desc_pop) begin
            if (desc_last) begin
                len_sum <= tx_pkg::PREAMBLE_LEN;
            end else begin
                len_sum <= len_sum + desc_len;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_q_if.sv
`timescale 1ns/100ps
`default_nettype none

interface frame_q_if;

    logic               push;
    tx_pkg::frame_len_t push_len;
    logic               push_no_fcs;
    logic               full;

    logic               pop;
    tx_pkg::frame_len_t head_len;
    logic               head_no_fcs;
    logic               not_empty;

    modport producer (
        output push, push_len, push_no_fcs,
        input  full
    );

    modport buffer (
        input  push, push_len, push_no_fcs, pop,
        output full, head_len, head_no_fcs, not_empty
    );

    modport consumer (
        output pop,
        input  head_len, head_no_fcs, not_empty
    );

endinterface

`default_nettype wire

// File: logic/tx_pkg.sv
`default_nettype none

package tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [63:0] word_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [15:0] ipg_t;
    typedef logic [31:0] crc_t;
    typedef logic [19:0] desc_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SEND_PAUSE,
        TX_SEND_ZERO,
        TX_SEND_DATA,
        TX_SEND_FCS,
        TX_WAIT_IPG
    } tx_state_t;

    // descriptor word: last, no fcs, byte length
    localparam int DESC_LAST_BIT   = 17;
    localparam int DESC_NO_FCS_BIT = 16;
    localparam int DESC_LEN_MSB    = 15;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // positions counted from the first preamble byte
    localparam frame_len_t PREAMBLE_LEN    = 16'd8;
    localparam frame_len_t PAUSE_FIELD_END = 16'd26;
    localparam frame_len_t PAUSE_LAST_POS  = 16'd59;
    localparam frame_len_t FCS_LEN         = 16'd4;

    localparam int BYTES_PER_WORD = 8;
    localparam int FRAME_Q_DEPTH  = 8;

    // reserved mac control multicast
    localparam logic [47:0] PAUSE_DEST = 48'h0180_C200_0001;

    localparam crc_t CRC_POLY = 32'hEDB8_8320;

endpackage

`default_nettype wire
